// File: Bender.yml
package:
  name: id_ex_subsys

sources:
  - common/cpu_isa_pkg.sv
  - common/pipe_pkg.sv
  - decode/instr_decoder.sv
  - design/reg_file.sv
  - design/id_ex_reg.sv
  - execute/execute_unit.sv
  - design/id_ex_subsys.sv
  - target: test
    files:
      - verification/id_ex_subsys_chk.sv
      - verification/tb_id_ex_subsys.sv

// File: common/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam int num_regs = 32;

    // Sequential instruction step and base of branch targets.
    localparam word_t pc_step = 32'd4;

    // Primary opcodes.
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_beq   = 6'h04;
    localparam opcode_t op_bne   = 6'h05;
    localparam opcode_t op_addiu = 6'h09;
    localparam opcode_t op_slti  = 6'h0a;
    localparam opcode_t op_andi  = 6'h0c;
    localparam opcode_t op_ori   = 6'h0d;
    localparam opcode_t op_xori  = 6'h0e;
    localparam opcode_t op_lui   = 6'h0f;
    localparam opcode_t op_lw    = 6'h23;
    localparam opcode_t op_sw    = 6'h2b;

    // Funct field of the R-type group.
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_sra  = 6'h03;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic {
        dst_rt,
        dst_rd
    } reg_dst_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne
    } branch_t;

    // A side is rs, or the shift amount for sll/srl/sra.
    typedef enum logic {
        src_a_rs,
        src_a_shamt
    } src_a_t;

    typedef enum logic {
        src_b_rt,
        src_b_imm
    } src_b_t;

    typedef struct packed {
        cpu_isa_pkg::alu_op_t alu_op;
        src_a_t               src_a;
        src_b_t               src_b;
        reg_dst_t             reg_dst;
        branch_t              branch;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 illegal;
    } ctrl_t;

    // All-zero bundle with no write, strobe or branch.
    localparam ctrl_t ctrl_nop = '0;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        cpu_isa_pkg::word_t     rs_val;
        cpu_isa_pkg::word_t     rt_val;
        cpu_isa_pkg::word_t     imm;    // Already extended.
        cpu_isa_pkg::shamt_t    shamt;
        cpu_isa_pkg::word_t     pc;
        cpu_isa_pkg::reg_addr_t rd;
        cpu_isa_pkg::reg_addr_t rt;
    } id_ex_t;

endpackage

`default_nettype wire

// File: decode/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  cpu_isa_pkg::word_t     instr,
    output pipe_pkg::ctrl_t        ctrl,
    output cpu_isa_pkg::reg_addr_t rs,
    output cpu_isa_pkg::reg_addr_t rt,
    output cpu_isa_pkg::reg_addr_t rd,
    output cpu_isa_pkg::word_t     imm,
    output cpu_isa_pkg::shamt_t    shamt
);

    cpu_isa_pkg::opcode_t opcode;
    cpu_isa_pkg::funct_t  funct;
    cpu_isa_pkg::imm16_t  imm16;
    logic                 zero_ext;
    logic                 is_shift;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    assign is_shift = (funct == cpu_isa_pkg::fn_sll) || (funct == cpu_isa_pkg::fn_srl) ||
                      (funct == cpu_isa_pkg::fn_sra);

    // Logical immediates are zero extended, everything else sign extended.
    assign imm = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    always_comb
    begin
        ctrl     = pipe_pkg::ctrl_nop;
        zero_ext = 1'b0;
        case (opcode)
            cpu_isa_pkg::op_rtype:
            begin
                ctrl.reg_dst   = pipe_pkg::dst_rd;
                ctrl.reg_write = 1'b1;
                ctrl.src_b     = pipe_pkg::src_b_rt;
                ctrl.src_a     = is_shift ? pipe_pkg::src_a_shamt : pipe_pkg::src_a_rs;
                case (funct)
                    cpu_isa_pkg::fn_addu: ctrl.alu_op = cpu_isa_pkg::alu_add;
                    cpu_isa_pkg::fn_subu: ctrl.alu_op = cpu_isa_pkg::alu_sub;
                    cpu_isa_pkg::fn_and:  ctrl.alu_op = cpu_isa_pkg::alu_and;
                    cpu_isa_pkg::fn_or:   ctrl.alu_op = cpu_isa_pkg::alu_or;
                    cpu_isa_pkg::fn_xor:  ctrl.alu_op = cpu_isa_pkg::alu_xor;
                    cpu_isa_pkg::fn_nor:  ctrl.alu_op = cpu_isa_pkg::alu_nor;
                    cpu_isa_pkg::fn_slt:  ctrl.alu_op = cpu_isa_pkg::alu_slt;
                    cpu_isa_pkg::fn_sltu: ctrl.alu_op = cpu_isa_pkg::alu_sltu;
                    cpu_isa_pkg::fn_sll:  ctrl.alu_op = cpu_isa_pkg::alu_sll;
                    cpu_isa_pkg::fn_srl:  ctrl.alu_op = cpu_isa_pkg::alu_srl;
                    cpu_isa_pkg::fn_sra:  ctrl.alu_op = cpu_isa_pkg::alu_sra;
                    default:
                    begin
                        ctrl         = pipe_pkg::ctrl_nop;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            cpu_isa_pkg::op_addiu, cpu_isa_pkg::op_slti, cpu_isa_pkg::op_lui:
            begin
                ctrl.src_b     = pipe_pkg::src_b_imm;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = (opcode == cpu_isa_pkg::op_addiu) ? cpu_isa_pkg::alu_add :
                                 (opcode == cpu_isa_pkg::op_slti)  ? cpu_isa_pkg::alu_slt :
                                                                     cpu_isa_pkg::alu_lui;
            end
            cpu_isa_pkg::op_andi, cpu_isa_pkg::op_ori, cpu_isa_pkg::op_xori:
            begin
                zero_ext       = 1'b1;
                ctrl.src_b     = pipe_pkg::src_b_imm;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = (opcode == cpu_isa_pkg::op_andi) ? cpu_isa_pkg::alu_and :
                                 (opcode == cpu_isa_pkg::op_ori)  ? cpu_isa_pkg::alu_or :
                                                                    cpu_isa_pkg::alu_xor;
            end
            cpu_isa_pkg::op_lw:
            begin
                ctrl.src_b     = pipe_pkg::src_b_imm;    // Address is rs + offset.
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            cpu_isa_pkg::op_sw:
            begin
                ctrl.src_b     = pipe_pkg::src_b_imm;
                ctrl.mem_write = 1'b1;
            end
            cpu_isa_pkg::op_beq: ctrl.branch = pipe_pkg::br_beq;
            cpu_isa_pkg::op_bne: ctrl.branch = pipe_pkg::br_bne;
            default:             ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clear,
    input  pipe_pkg::id_ex_t id_bundle,
    output pipe_pkg::id_ex_t ex_bundle
);

    logic             valid_q;
    pipe_pkg::ctrl_t  ctrl_q;
    pipe_pkg::id_ex_t payload_q;

    // Control half. Reset and clear both load a bubble.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= pipe_pkg::ctrl_nop;
        end
        else if (clear)
        begin
            valid_q <= 1'b0;
            ctrl_q  <= pipe_pkg::ctrl_nop;    // Flushed slot carries no write or strobe.
        end
        else
        begin
            valid_q <= id_bundle.valid;
            ctrl_q  <= id_bundle.ctrl;
        end
    end

    // Operands, immediate, pc and register numbers.
    always_ff @(posedge clk)
    begin
        payload_q <= id_bundle;
    end

    always_comb
    begin
        ex_bundle       = payload_q;
        ex_bundle.valid = valid_q;
        ex_bundle.ctrl  = ctrl_q;
    end

endmodule

`default_nettype wire

// File: design/id_ex_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_subsys (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clear,
    input  logic                   instr_valid,
    input  cpu_isa_pkg::word_t     instr,
    input  cpu_isa_pkg::word_t     pc,
    input  logic                   wb_en,
    input  cpu_isa_pkg::reg_addr_t wb_addr,
    input  cpu_isa_pkg::word_t     wb_data,
    output logic                   ex_valid,
    output cpu_isa_pkg::word_t     ex_result,
    output cpu_isa_pkg::word_t     ex_store_data,
    output cpu_isa_pkg::reg_addr_t ex_dest,
    output logic                   ex_reg_write,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_branch_taken,
    output cpu_isa_pkg::word_t     ex_branch_target,
    output logic                   ex_illegal
);

    pipe_pkg::ctrl_t        dec_ctrl;
    cpu_isa_pkg::reg_addr_t dec_rs;
    cpu_isa_pkg::reg_addr_t dec_rt;
    cpu_isa_pkg::reg_addr_t dec_rd;
    cpu_isa_pkg::word_t     dec_imm;
    cpu_isa_pkg::shamt_t    dec_shamt;
    cpu_isa_pkg::word_t     rs_val;
    cpu_isa_pkg::word_t     rt_val;
    pipe_pkg::id_ex_t       id_bundle;
    pipe_pkg::id_ex_t       ex_bundle;

    instr_decoder instr_decoder_i (
        .instr (instr),
        .ctrl  (dec_ctrl),
        .rs    (dec_rs),
        .rt    (dec_rt),
        .rd    (dec_rd),
        .imm   (dec_imm),
        .shamt (dec_shamt)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (dec_rs),
        .rt_addr (dec_rt),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wr_en   (wb_en),
        .wr_addr (wb_addr),
        .wr_data (wb_data)
    );

    // Decode stage output, captured by ID/EX on the next edge.
    assign id_bundle = '{
        valid:  instr_valid,
        ctrl:   dec_ctrl,
        rs_val: rs_val,
        rt_val: rt_val,
        imm:    dec_imm,
        shamt:  dec_shamt,
        pc:     pc,
        rd:     dec_rd,
        rt:     dec_rt
    };

    id_ex_reg id_ex_reg_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .id_bundle (id_bundle),
        .ex_bundle (ex_bundle)
    );

    execute_unit execute_unit_i (
        .ex_bundle        (ex_bundle),
        .ex_valid         (ex_valid),
        .ex_result        (ex_result),
        .ex_store_data    (ex_store_data),
        .ex_dest          (ex_dest),
        .ex_reg_write     (ex_reg_write),
        .ex_mem_read      (ex_mem_read),
        .ex_mem_write     (ex_mem_write),
        .ex_branch_taken  (ex_branch_taken),
        .ex_branch_target (ex_branch_target),
        .ex_illegal       (ex_illegal)
    );

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_isa_pkg::reg_addr_t rs_addr,
    input  cpu_isa_pkg::reg_addr_t rt_addr,
    output cpu_isa_pkg::word_t     rs_val,
    output cpu_isa_pkg::word_t     rt_val,
    input  logic                   wr_en,
    input  cpu_isa_pkg::reg_addr_t wr_addr,
    input  cpu_isa_pkg::word_t     wr_data
);

    cpu_isa_pkg::word_t regs [cpu_isa_pkg::num_regs];
    logic               wr_live;

    assign wr_live = wr_en && (wr_addr != '0);    // Register zero ignores writes.

    // Write-first bypass makes a read of the register being written see the new value.
    function automatic cpu_isa_pkg::word_t read_port(input cpu_isa_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wr_live && (wr_addr == addr))
            return wr_data;
        return regs[addr];
    endfunction

    always_comb
    begin
        rs_val = read_port(rs_addr);
        rt_val = read_port(rt_addr);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < cpu_isa_pkg::num_regs; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: execute/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  pipe_pkg::id_ex_t       ex_bundle,
    output logic                   ex_valid,
    output cpu_isa_pkg::word_t     ex_result,
    output cpu_isa_pkg::word_t     ex_store_data,
    output cpu_isa_pkg::reg_addr_t ex_dest,
    output logic                   ex_reg_write,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_branch_taken,
    output cpu_isa_pkg::word_t     ex_branch_target,
    output logic                   ex_illegal
);

    pipe_pkg::ctrl_t     ctrl;
    cpu_isa_pkg::word_t  op_a;
    cpu_isa_pkg::word_t  op_b;
    cpu_isa_pkg::shamt_t sh;
    logic                rs_eq_rt;
    logic                taken;

    assign ctrl = ex_bundle.ctrl;

    assign op_a = (ctrl.src_a == pipe_pkg::src_a_rs) ? ex_bundle.rs_val :
                  cpu_isa_pkg::word_t'(ex_bundle.shamt);
    assign op_b = (ctrl.src_b == pipe_pkg::src_b_rt) ? ex_bundle.rt_val : ex_bundle.imm;
    assign sh   = op_a[4:0];

    always_comb
    begin
        case (ctrl.alu_op)
            cpu_isa_pkg::alu_add:  ex_result = op_a + op_b;
            cpu_isa_pkg::alu_sub:  ex_result = op_a - op_b;
            cpu_isa_pkg::alu_and:  ex_result = op_a & op_b;
            cpu_isa_pkg::alu_or:   ex_result = op_a | op_b;
            cpu_isa_pkg::alu_xor:  ex_result = op_a ^ op_b;
            cpu_isa_pkg::alu_nor:  ex_result = ~(op_a | op_b);
            cpu_isa_pkg::alu_slt:  ex_result = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_isa_pkg::alu_sltu: ex_result = {31'b0, op_a < op_b};
            cpu_isa_pkg::alu_sll:  ex_result = op_b << sh;
            cpu_isa_pkg::alu_srl:  ex_result = op_b >> sh;
            cpu_isa_pkg::alu_sra:  ex_result = $signed(op_b) >>> sh;
            cpu_isa_pkg::alu_lui:  ex_result = {op_b[15:0], 16'h0000};
            default:               ex_result = '0;
        endcase
    end

    assign ex_dest       = (ctrl.reg_dst == pipe_pkg::dst_rt) ? ex_bundle.rt : ex_bundle.rd;
    assign ex_store_data = ex_bundle.rt_val;

    // Branches compare the raw register values, not the B operand.
    assign rs_eq_rt = (ex_bundle.rs_val == ex_bundle.rt_val);

    always_comb
    begin
        case (ctrl.branch)
            pipe_pkg::br_none: taken = 1'b0;
            pipe_pkg::br_beq:  taken = rs_eq_rt;
            pipe_pkg::br_bne:  taken = !rs_eq_rt;
            default:           taken = 1'b0;
        endcase
    end

    assign ex_branch_target = ex_bundle.pc + cpu_isa_pkg::pc_step + {ex_bundle.imm[29:0], 2'b00};

    assign ex_valid        = ex_bundle.valid;
    assign ex_reg_write    = ex_bundle.valid && ctrl.reg_write;
    assign ex_mem_read     = ex_bundle.valid && ctrl.mem_read;
    assign ex_mem_write    = ex_bundle.valid && ctrl.mem_write;
    assign ex_branch_taken = ex_bundle.valid && taken;
    assign ex_illegal      = ex_bundle.valid && ctrl.illegal;

endmodule

`default_nettype wire

// File: src.f
common/cpu_isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decoder.sv
design/reg_file.sv
design/id_ex_reg.sv
execute/execute_unit.sv
design/id_ex_subsys.sv
verification/id_ex_subsys_chk.sv
verification/tb_id_ex_subsys.sv

// File: verification/id_ex_subsys_chk.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_subsys_chk (
    input logic clk,
    input logic arst_n,
    input logic clear,
    input logic ex_valid,
    input logic ex_reg_write,
    input logic ex_mem_read,
    input logic ex_mem_write,
    input logic ex_branch_taken,
    input logic ex_illegal
);

    // A flushed slot is a bubble.
    assert property (@(posedge clk) disable iff (!arst_n) clear |=> !ex_valid)
        else $error("ex_valid high in the cycle after clear");

    assert property (@(posedge clk) disable iff (!arst_n) !(ex_mem_read && ex_mem_write))
        else $error("ex_mem_read and ex_mem_write both high");

    assert property (@(posedge clk) disable iff (!arst_n)
        ex_illegal |-> !(ex_reg_write || ex_mem_read || ex_mem_write || ex_branch_taken))
        else $error("Illegal instruction with a write or strobe");

    assert property (@(posedge clk) disable iff (!arst_n) ex_branch_taken |-> ex_valid)
        else $error("Branch taken from an empty slot");

endmodule

bind id_ex_subsys id_ex_subsys_chk id_ex_subsys_chk_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .clear           (clear),
    .ex_valid        (ex_valid),
    .ex_reg_write    (ex_reg_write),
    .ex_mem_read     (ex_mem_read),
    .ex_mem_write    (ex_mem_write),
    .ex_branch_taken (ex_branch_taken),
    .ex_illegal      (ex_illegal)
);

`default_nettype wire

// File: verification/tb_id_ex_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_ex_subsys;

    localparam int unsigned rand_seed      = 32'h98df_5cab;
    localparam int          num_cycles     = 3000;
    localparam int          reset_wait_max = 20;

    // Expected response of one slot.
    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   taken;
        logic                   illegal;
        logic                   has_result;
        logic                   has_target;
        cpu_isa_pkg::word_t     result;
        cpu_isa_pkg::word_t     store_data;
        cpu_isa_pkg::word_t     target;
        cpu_isa_pkg::reg_addr_t dest;
    } expect_t;

    localparam expect_t idle_slot = '0;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   clear;
    logic                   instr_valid;
    cpu_isa_pkg::word_t     instr;
    cpu_isa_pkg::word_t     pc;
    logic                   wb_en;
    cpu_isa_pkg::reg_addr_t wb_addr;
    cpu_isa_pkg::word_t     wb_data;
    logic                   ex_valid;
    cpu_isa_pkg::word_t     ex_result;
    cpu_isa_pkg::word_t     ex_store_data;
    cpu_isa_pkg::reg_addr_t ex_dest;
    logic                   ex_reg_write;
    logic                   ex_mem_read;
    logic                   ex_mem_write;
    logic                   ex_branch_taken;
    cpu_isa_pkg::word_t     ex_branch_target;
    logic                   ex_illegal;

    cpu_isa_pkg::word_t   model_regs [cpu_isa_pkg::num_regs];
    expect_t              pending;
    expect_t              current;
    int                   wait_count;

    cpu_isa_pkg::funct_t rtype_fn [11] = '{cpu_isa_pkg::fn_addu, cpu_isa_pkg::fn_subu,
        cpu_isa_pkg::fn_and, cpu_isa_pkg::fn_or, cpu_isa_pkg::fn_xor, cpu_isa_pkg::fn_nor,
        cpu_isa_pkg::fn_slt, cpu_isa_pkg::fn_sltu, cpu_isa_pkg::fn_sll, cpu_isa_pkg::fn_srl,
        cpu_isa_pkg::fn_sra};
    cpu_isa_pkg::opcode_t itype_op [10] = '{cpu_isa_pkg::op_addiu, cpu_isa_pkg::op_andi,
        cpu_isa_pkg::op_ori, cpu_isa_pkg::op_xori, cpu_isa_pkg::op_slti, cpu_isa_pkg::op_lui,
        cpu_isa_pkg::op_lw, cpu_isa_pkg::op_sw, cpu_isa_pkg::op_beq, cpu_isa_pkg::op_bne};

    always #4 clk = ~clk;

    id_ex_subsys id_ex_subsys_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .clear            (clear),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .pc               (pc),
        .wb_en            (wb_en),
        .wb_addr          (wb_addr),
        .wb_data          (wb_data),
        .ex_valid         (ex_valid),
        .ex_result        (ex_result),
        .ex_store_data    (ex_store_data),
        .ex_dest          (ex_dest),
        .ex_reg_write     (ex_reg_write),
        .ex_mem_read      (ex_mem_read),
        .ex_mem_write     (ex_mem_write),
        .ex_branch_taken  (ex_branch_taken),
        .ex_branch_target (ex_branch_target),
        .ex_illegal       (ex_illegal)
    );

    task automatic check_word(input string name, input cpu_isa_pkg::word_t got,
                              input cpu_isa_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_reg_addr(input string name, input cpu_isa_pkg::reg_addr_t got,
                                  input cpu_isa_pkg::reg_addr_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_flag("ex_valid", ex_valid, e.valid);
        check_flag("ex_reg_write", ex_reg_write, e.reg_write);
        check_flag("ex_mem_read", ex_mem_read, e.mem_read);
        check_flag("ex_mem_write", ex_mem_write, e.mem_write);
        check_flag("ex_branch_taken", ex_branch_taken, e.taken);
        check_flag("ex_illegal", ex_illegal, e.illegal);
        if (e.valid && !e.illegal)
        begin
            check_reg_addr("ex_dest", ex_dest, e.dest);
            check_word("ex_store_data", ex_store_data, e.store_data);
            if (e.has_result)
                check_word("ex_result", ex_result, e.result);
            if (e.has_target)
                check_word("ex_branch_target", ex_branch_target, e.target);
        end
    endtask

    // Mostly registers 0..7, so reads often hit the register being written.
    function automatic cpu_isa_pkg::reg_addr_t pick_reg();
        if ($urandom_range(3, 0) == 0)
            return cpu_isa_pkg::reg_addr_t'($urandom_range(31, 0));
        return cpu_isa_pkg::reg_addr_t'($urandom_range(7, 0));
    endfunction

    function automatic logic is_legal(input cpu_isa_pkg::word_t w);
        logic ok;
        ok = 1'b0;
        if (w[31:26] == cpu_isa_pkg::op_rtype)
        begin
            foreach (rtype_fn[i])
                ok = ok || (w[5:0] == rtype_fn[i]);
        end
        else
        begin
            foreach (itype_op[i])
                ok = ok || (w[31:26] == itype_op[i]);
        end
        return ok;
    endfunction

    function automatic cpu_isa_pkg::word_t gen_instr();
        cpu_isa_pkg::word_t w;
        int unsigned        pick;
        pick = $urandom_range(99, 0);
        if (pick < 5)
        begin
            w = $urandom;
            if (is_legal(w))
                w = {cpu_isa_pkg::op_rtype, w[25:6], 6'h3f};    // Unused funct.
        end
        else if (pick < 55)
            w = {cpu_isa_pkg::op_rtype, pick_reg(), pick_reg(), pick_reg(), 5'($urandom),
                 rtype_fn[$urandom_range(10, 0)]};
        else
            w = {itype_op[$urandom_range(9, 0)], pick_reg(), pick_reg(), 16'($urandom)};
        return w;
    endfunction

    // Register read with write-first bypass and a zero register.
    function automatic cpu_isa_pkg::word_t model_read(input cpu_isa_pkg::reg_addr_t a,
            input logic we, input cpu_isa_pkg::reg_addr_t wa, input cpu_isa_pkg::word_t wd);
        if (a == '0)
            return '0;
        if (we && (wa == a))
            return wd;
        return model_regs[a];
    endfunction

    function automatic expect_t model_instr(input logic valid, input cpu_isa_pkg::word_t w,
            input cpu_isa_pkg::word_t pc_v, input cpu_isa_pkg::word_t rs_v,
            input cpu_isa_pkg::word_t rt_v);
        expect_t             e;
        cpu_isa_pkg::shamt_t sh;
        cpu_isa_pkg::word_t  sext;
        cpu_isa_pkg::word_t  zext;
        e    = '0;
        sh   = w[10:6];
        sext = {{16{w[15]}}, w[15:0]};
        zext = {16'h0000, w[15:0]};
        if (!valid)
            return e;
        e.valid      = 1'b1;
        e.store_data = rt_v;
        e.dest       = w[20:16];
        e.has_result = 1'b1;
        e.reg_write  = 1'b1;
        case (w[31:26])
            cpu_isa_pkg::op_rtype:
            begin
                e.dest = w[15:11];
                case (w[5:0])
                    cpu_isa_pkg::fn_addu: e.result = rs_v + rt_v;
                    cpu_isa_pkg::fn_subu: e.result = rs_v - rt_v;
                    cpu_isa_pkg::fn_and:  e.result = rs_v & rt_v;
                    cpu_isa_pkg::fn_or:   e.result = rs_v | rt_v;
                    cpu_isa_pkg::fn_xor:  e.result = rs_v ^ rt_v;
                    cpu_isa_pkg::fn_nor:  e.result = ~(rs_v | rt_v);
                    cpu_isa_pkg::fn_slt:  e.result = ($signed(rs_v) < $signed(rt_v)) ? 1 : 0;
                    cpu_isa_pkg::fn_sltu: e.result = (rs_v < rt_v) ? 1 : 0;
                    cpu_isa_pkg::fn_sll:  e.result = rt_v << sh;
                    cpu_isa_pkg::fn_srl:  e.result = rt_v >> sh;
                    cpu_isa_pkg::fn_sra:  e.result = $signed(rt_v) >>> sh;
                    default:              e.illegal = 1'b1;
                endcase
            end
            cpu_isa_pkg::op_addiu: e.result = rs_v + sext;
            cpu_isa_pkg::op_slti:  e.result = ($signed(rs_v) < $signed(sext)) ? 1 : 0;
            cpu_isa_pkg::op_andi:  e.result = rs_v & zext;
            cpu_isa_pkg::op_ori:   e.result = rs_v | zext;
            cpu_isa_pkg::op_xori:  e.result = rs_v ^ zext;
            cpu_isa_pkg::op_lui:   e.result = {w[15:0], 16'h0000};
            cpu_isa_pkg::op_lw:
            begin
                e.result   = rs_v + sext;    // Load address.
                e.mem_read = 1'b1;
            end
            cpu_isa_pkg::op_sw:
            begin
                e.result    = rs_v + sext;
                e.mem_write = 1'b1;
                e.reg_write = 1'b0;
            end
            cpu_isa_pkg::op_beq, cpu_isa_pkg::op_bne:
            begin
                e.reg_write  = 1'b0;
                e.has_result = 1'b0;
                e.has_target = 1'b1;
                e.target     = pc_v + 32'd4 + (sext << 2);
                e.taken      = (w[31:26] == cpu_isa_pkg::op_beq) ? (rs_v == rt_v) :
                                                                   (rs_v != rt_v);
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal)
        begin
            e         = '0;
            e.valid   = 1'b1;
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic drive_cycle();
        logic                   v;
        logic                   clr;
        logic                   we;
        cpu_isa_pkg::reg_addr_t wa;
        cpu_isa_pkg::word_t     wd;
        cpu_isa_pkg::word_t     w;
        cpu_isa_pkg::word_t     pc_v;
        cpu_isa_pkg::word_t     rs_v;
        cpu_isa_pkg::word_t     rt_v;
        v    = ($urandom_range(99, 0) >= 15);
        clr  = ($urandom_range(99, 0) < 10);
        we   = ($urandom_range(1, 0) == 1);
        wa   = pick_reg();
        wd   = $urandom;
        w    = gen_instr();
        pc_v = cpu_isa_pkg::word_t'($urandom) & 32'hffff_fffc;
        rs_v = model_read(w[25:21], we, wa, wd);
        rt_v = model_read(w[20:16], we, wa, wd);
        pending = model_instr(v && !clr, w, pc_v, rs_v, rt_v);
        if (we && (wa != '0))
            model_regs[wa] = wd;
        instr_valid <= v;
        clear       <= clr;
        instr       <= w;
        pc          <= pc_v;
        wb_en       <= we;
        wb_addr     <= wa;
        wb_data     <= wd;
    endtask

    initial
    begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

    initial
    begin
        void'($urandom(rand_seed));
        clear       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        pending     = idle_slot;
        wait_count  = 0;
        for (int i = 0; i < cpu_isa_pkg::num_regs; i++)
            model_regs[i] = '0;

        while (arst_n !== 1'b1)
        begin
            @(negedge clk);
            check_outputs(idle_slot);    // Nothing leaves the stage in reset.
            wait_count++;
            if (wait_count > reset_wait_max)
            begin
                $display("Reset was not released after %0d cycles", reset_wait_max);
                $display("Simulation failed");
                $fatal(1, "Reset release timeout");
            end
        end

        repeat (num_cycles)
        begin
            @(posedge clk);
            current = pending;    // Slot captured at this edge.
            drive_cycle();
            @(negedge clk);
            check_outputs(current);
        end

        $display("Checked %0d cycles", num_cycles);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
